//--- sources.f
+incdir+bench
source/rvc_pkg.sv
source/rvc_field_decode.sv
source/rvc_imm_gen.sv
source/rvc_ctrl_stage.sv
source/rvc_decode_top.sv
bench/tb_rvc_decode.sv

//--- bench/tb_rvc_vectors.svh
`ifndef TB_RVC_VECTORS_SVH
`define TB_RVC_VECTORS_SVH

// columns: inst, rs1, rs2, rd, alu, imm, offset, imm_sel, data_sel, op_a, op_b,
//          wr_en, mem_load, mem_store, branch_type, is_compressed
task automatic load_vectors();
    add_vec('h952E, 10, 11, 10,  1, 'hffffffeb, 'hffffff6a, 0, 1, 1, 0, 1, 0, 0, 0, 1);  // add
    add_vec('h829A,  0,  6,  5,  1, 'h00000006, 'h00000006, 0, 1, 1, 0, 1, 0, 0, 0, 1);  // mv
    add_vec('h8C05,  8,  9,  8,  2, 'h00000001, 'h00000038, 0, 1, 1, 0, 1, 0, 0, 0, 1);  // sub
    add_vec('h8D2D, 10, 11, 10,  5, 'h0000000b, 'h0000007a, 0, 1, 1, 0, 1, 0, 0, 0, 1);  // xor
    add_vec('h8E55, 12, 13, 12,  4, 'h00000015, 'h000000bc, 0, 1, 1, 0, 1, 0, 0, 0, 1);  // or
    add_vec('h8F7D, 14, 15, 14,  3, 'h0000001f, 'h000000fe, 0, 1, 1, 0, 1, 0, 0, 0, 1);  // and
    add_vec('h98FD,  9,  0,  9,  3, 'hffffffff, 'hfffffff6, 0, 1, 1, 1, 1, 0, 0, 0, 1);  // andi -1
    add_vec('h910D, 10,  0, 10,  9, 'h00000023, 'h00000122, 0, 1, 1, 1, 1, 0, 0, 0, 1);  // srli
    add_vec('h8595, 11,  0, 11, 10, 'h00000005, 'h0000002c, 0, 1, 1, 1, 1, 0, 0, 0, 1);  // srai
    add_vec('h038E,  7,  0,  7,  8, 'h00000003, 'h00000022, 0, 1, 1, 1, 1, 0, 0, 0, 1);  // slli
    add_vec('h5675,  0,  0, 12,  1, 'hfffffffd, 'hffffffec, 0, 1, 1, 1, 1, 0, 0, 0, 1);  // li -3
    add_vec('h0095,  1,  0,  1,  1, 'h00000005, 'h00000024, 0, 1, 1, 1, 1, 0, 0, 0, 1);  // addi
    add_vec('h7139,  2,  0,  2,  1, 'hffffffc0, 'hffffff46, 0, 1, 1, 1, 1, 0, 0, 0, 1);  // addi16sp
    add_vec('h7285,  0,  0,  5,  1, 'hfffe1000, 'hffffff20, 2, 2, 0, 1, 1, 0, 0, 0, 1);  // lui
    add_vec('h1FE0,  2,  0,  8,  1, 'h000003fc, 'h000001d8, 0, 1, 1, 1, 1, 0, 0, 0, 1);  // addi4spn
    add_vec('h5D64, 10,  0,  9,  1, 'h0000007c, 'h000001f8, 0, 3, 1, 1, 1, 2, 0, 0, 1);  // lw
    add_vec('hC24C, 12, 11,  0,  1, 'h00000004, 'h000000a2, 1, 1, 1, 1, 0, 0, 2, 0, 1);  // sw
    add_vec('h57FE,  2,  0, 15,  1, 'h000000fc, 'h000001ee, 0, 3, 1, 1, 1, 2, 0, 0, 1);  // lwsp
    add_vec('hC326,  2,  9,  0,  1, 'h00000084, 'h00000060, 1, 1, 1, 1, 0, 0, 2, 0, 1);  // swsp
    add_vec('hBFFD,  0,  0,  0,  1, 'hffffffff, 'hfffffffe, 4, 1, 1, 1, 1, 0, 0, 0, 1);  // j -2
    add_vec('h2FFD,  0,  0,  1,  1, 'h0000001f, 'h000007fe, 4, 1, 1, 1, 1, 0, 0, 0, 1);  // jal
    add_vec('hDC75,  8,  0,  0,  2, 'hfffffffd, 'hfffffffc, 3, 1, 1, 0, 0, 0, 0, 2, 1);  // beqz
    add_vec('hE399, 15,  0,  0,  2, 'h00000006, 'h00000006, 3, 1, 1, 0, 0, 0, 0, 1, 1);  // bnez
    add_vec('h8282,  5,  0,  0,  1, 'h00000000, 'h00000000, 4, 0, 0, 1, 1, 0, 0, 0, 1);  // jr
    add_vec('h9302,  6,  0,  1,  1, 'hffffffe0, 'hffffff00, 4, 0, 0, 1, 1, 0, 0, 0, 1);  // jalr
    // all-zero word decodes as addi4spn but never writes
    add_vec('h0000,  2,  0,  8,  1, 'h00000000, 'h00000000, 0, 1, 1, 1, 0, 0, 0, 0, 1);
    add_vec('h0013,  0,  0,  0,  1, 'h00000004, 'h00000004, 0, 1, 1, 1, 1, 0, 0, 0, 0);  // quad 3
endtask

`endif

//--- bench/tb_rvc_decode.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rvc_decode;

    localparam int XLEN_T        = 32;
    localparam int RESET_CYCLES  = 5;
    localparam int VALID_TIMEOUT = 1;  // result due one cycle after sampling

    typedef struct packed {
        logic [15:0] inst;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [3:0]  alu;
        logic [31:0] imm;
        logic [31:0] off;
        logic [2:0]  imm_sel;
        logic [1:0]  data_sel;
        logic        op_a;
        logic        op_b;
        logic        wr_en;
        logic [1:0]  mem_ld;
        logic [1:0]  mem_st;
        logic [1:0]  br;
        logic        comp;
    } vec_t;

    logic              i_clk;
    logic              i_arst_n;
    logic              i_valid;
    logic [15:0]       i_inst;
    logic              o_valid;
    logic              o_is_compressed;
    logic [1:0]        o_mem_load;
    logic [1:0]        o_mem_store;
    logic [2:0]        o_imm_sel;
    logic [1:0]        o_data_sel;
    logic              o_sel_op_a;
    logic              o_sel_op_b;
    logic              o_wr_en;
    logic [1:0]        o_branch_type;
    logic [4:0]        o_rs1;
    logic [4:0]        o_rs2;
    logic [4:0]        o_rd;
    logic [3:0]        o_alu_op;
    logic [XLEN_T-1:0] o_imm;
    logic [XLEN_T-1:0] o_offset;

    vec_t vecs[$];
    int   errors;

    rvc_decode_top #(.XLEN_P(XLEN_T)) dut0 (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_valid         (i_valid),
        .i_inst          (i_inst),
        .o_valid         (o_valid),
        .o_is_compressed (o_is_compressed),
        .o_mem_load      (o_mem_load),
        .o_mem_store     (o_mem_store),
        .o_imm_sel       (o_imm_sel),
        .o_data_sel      (o_data_sel),
        .o_sel_op_a      (o_sel_op_a),
        .o_sel_op_b      (o_sel_op_b),
        .o_wr_en         (o_wr_en),
        .o_branch_type   (o_branch_type),
        .o_rs1           (o_rs1),
        .o_rs2           (o_rs2),
        .o_rd            (o_rd),
        .o_alu_op        (o_alu_op),
        .o_imm           (o_imm),
        .o_offset        (o_offset)
    );

    always #2 i_clk = ~i_clk;

    `include "tb_rvc_vectors.svh"

    task automatic add_vec(input logic [15:0] inst, input int rs1, input int rs2,
                           input int rd, input int alu, input logic [31:0] imm,
                           input logic [31:0] off, input int imm_sel, input int data_sel,
                           input int op_a, input int op_b, input int wr_en,
                           input int mem_ld, input int mem_st, input int br,
                           input int comp);
        vec_t v;
        v.inst     = inst;
        v.rs1      = 5'(rs1);
        v.rs2      = 5'(rs2);
        v.rd       = 5'(rd);
        v.alu      = 4'(alu);
        v.imm      = imm;
        v.off      = off;
        v.imm_sel  = 3'(imm_sel);
        v.data_sel = 2'(data_sel);
        v.op_a     = 1'(op_a);
        v.op_b     = 1'(op_b);
        v.wr_en    = 1'(wr_en);
        v.mem_ld   = 2'(mem_ld);
        v.mem_st   = 2'(mem_st);
        v.br       = 2'(br);
        v.comp     = 1'(comp);
        vecs.push_back(v);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("error %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_idle_outputs(input string tag);
        check_field({tag, " o_valid"}, 32'(o_valid), 0);
        check_field({tag, " o_wr_en"}, 32'(o_wr_en), 0);
        check_field({tag, " o_mem_load"}, 32'(o_mem_load), 0);
        check_field({tag, " o_mem_store"}, 32'(o_mem_store), 0);
    endtask

    task automatic check_row(input vec_t v, input int idx);
        string t;
        t = $sformatf("row %0d (%h)", idx, v.inst);
        check_field({t, " o_rs1"}, 32'(o_rs1), 32'(v.rs1));
        check_field({t, " o_rs2"}, 32'(o_rs2), 32'(v.rs2));
        check_field({t, " o_rd"}, 32'(o_rd), 32'(v.rd));
        check_field({t, " o_alu_op"}, 32'(o_alu_op), 32'(v.alu));
        check_field({t, " o_imm"}, o_imm, v.imm);
        check_field({t, " o_offset"}, o_offset, v.off);
        check_field({t, " o_imm_sel"}, 32'(o_imm_sel), 32'(v.imm_sel));
        check_field({t, " o_data_sel"}, 32'(o_data_sel), 32'(v.data_sel));
        check_field({t, " o_sel_op_a"}, 32'(o_sel_op_a), 32'(v.op_a));
        check_field({t, " o_sel_op_b"}, 32'(o_sel_op_b), 32'(v.op_b));
        check_field({t, " o_wr_en"}, 32'(o_wr_en), 32'(v.wr_en));
        check_field({t, " o_mem_load"}, 32'(o_mem_load), 32'(v.mem_ld));
        check_field({t, " o_mem_store"}, 32'(o_mem_store), 32'(v.mem_st));
        check_field({t, " o_branch_type"}, 32'(o_branch_type), 32'(v.br));
        check_field({t, " o_is_compressed"}, 32'(o_is_compressed), 32'(v.comp));
    endtask

    // polls at falling edges so outputs are settled
    task automatic wait_valid(input int max_cycles, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < max_cycles) begin
            @(negedge i_clk);
            if (o_valid === 1'b1) ok = 1'b1;
            n++;
        end
    endtask

    initial begin
        int n;
        bit ok;
        errors   = 0;
        i_clk    = 1'b0;
        i_arst_n = 1'b0;
        i_valid  = 1'b0;
        i_inst   = '0;
        load_vectors();

        n = 0;
        while (n < RESET_CYCLES) begin
            @(negedge i_clk);
            check_idle_outputs("in reset");
            n++;
        end
        @(posedge i_clk);
        i_arst_n <= 1'b1;
        @(negedge i_clk);
        check_idle_outputs("after reset");

        // each cycle drives one row and checks the row before it
        for (int i = 0; i <= vecs.size(); i++) begin
            @(posedge i_clk);
            if (i < vecs.size()) begin
                i_valid <= 1'b1;
                i_inst  <= vecs[i].inst;
            end else begin
                i_valid <= 1'b0;
                i_inst  <= 16'hC326;  // swsp word that must not reach the outputs
            end
            if (i > 0) begin
                wait_valid(VALID_TIMEOUT, ok);
                if (!ok) begin
                    $display("timeout: o_valid never rose for row %0d", i - 1);
                    $display("Some tests failed");
                    $finish;
                end
                check_row(vecs[i-1], i - 1);
            end
        end

        // idle cycle drops o_valid and keeps the last result
        @(posedge i_clk);
        @(negedge i_clk);
        check_field("idle o_valid", 32'(o_valid), 0);
        check_row(vecs[vecs.size()-1], vecs.size() - 1);

        $display("summary: %0d errors over %0d rows", errors, vecs.size());
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/rvc_decode_top.sv
`timescale 1ns/1ns
`default_nettype none

module rvc_decode_top #(
    parameter int XLEN_P = rvc_pkg::XLEN
) (
    input  logic                       i_clk,
    input  logic                       i_arst_n,
    input  logic                       i_valid,
    input  logic [rvc_pkg::INST_W-1:0] i_inst,
    output logic                       o_valid,
    output logic                       o_is_compressed,
    output logic [1:0]                 o_mem_load,
    output logic [1:0]                 o_mem_store,
    output logic [2:0]                 o_imm_sel,
    output logic [1:0]                 o_data_sel,
    output logic                       o_sel_op_a,
    output logic                       o_sel_op_b,
    output logic                       o_wr_en,
    output logic [1:0]                 o_branch_type,
    output logic [rvc_pkg::REG_W-1:0]  o_rs1,
    output logic [rvc_pkg::REG_W-1:0]  o_rs2,
    output logic [rvc_pkg::REG_W-1:0]  o_rd,
    output logic [rvc_pkg::OP_W-1:0]   o_alu_op,
    output logic [XLEN_P-1:0]          o_imm,
    output logic [XLEN_P-1:0]          o_offset
);
    import rvc_pkg::*;

    logic [REG_W-1:0]  rs1;
    logic [REG_W-1:0]  rs2;
    logic [REG_W-1:0]  rd;
    logic [OP_W-1:0]   alu_op;
    logic              cls_load;
    logic              cls_store;
    logic              cls_branch;
    logic              cls_jump;
    logic              cls_jreg;
    logic              cls_lui;
    logic              cls_reg;
    logic [XLEN_P-1:0] imm;
    logic [XLEN_P-1:0] offset;

    rvc_field_decode u_field (
        .i_inst       (i_inst),
        .o_rs1        (rs1),
        .o_rs2        (rs2),
        .o_rd         (rd),
        .o_alu_op     (alu_op),
        .o_cls_load   (cls_load),
        .o_cls_store  (cls_store),
        .o_cls_branch (cls_branch),
        .o_cls_jump   (cls_jump),
        .o_cls_jreg   (cls_jreg),
        .o_cls_lui    (cls_lui),
        .o_cls_reg    (cls_reg)
    );

    rvc_imm_gen #(.XLEN_P(XLEN_P)) u_imm (
        .i_inst   (i_inst),
        .o_imm    (imm),
        .o_offset (offset)
    );

    // the only clocked stage
    rvc_ctrl_stage #(.XLEN_P(XLEN_P)) u_ctrl (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_valid         (i_valid),
        .i_inst          (i_inst),
        .i_rs1           (rs1),
        .i_rs2           (rs2),
        .i_rd            (rd),
        .i_alu_op        (alu_op),
        .i_cls_load      (cls_load),
        .i_cls_store     (cls_store),
        .i_cls_branch    (cls_branch),
        .i_cls_jump      (cls_jump),
        .i_cls_jreg      (cls_jreg),
        .i_cls_lui       (cls_lui),
        .i_cls_reg       (cls_reg),
        .i_imm           (imm),
        .i_offset        (offset),
        .o_valid         (o_valid),
        .o_is_compressed (o_is_compressed),
        .o_mem_load      (o_mem_load),
        .o_mem_store     (o_mem_store),
        .o_imm_sel       (o_imm_sel),
        .o_data_sel      (o_data_sel),
        .o_sel_op_a      (o_sel_op_a),
        .o_sel_op_b      (o_sel_op_b),
        .o_wr_en         (o_wr_en),
        .o_branch_type   (o_branch_type),
        .o_rs1           (o_rs1),
        .o_rs2           (o_rs2),
        .o_rd            (o_rd),
        .o_alu_op        (o_alu_op),
        .o_imm           (o_imm),
        .o_offset        (o_offset)
    );

endmodule

`default_nettype wire

//--- source/rvc_ctrl_stage.sv
`timescale 1ns/1ns
`default_nettype none

module rvc_ctrl_stage #(
    parameter int XLEN_P = rvc_pkg::XLEN
) (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic                      i_valid,
    input  rvc_pkg::rvc_inst_u        i_inst,
    input  logic [rvc_pkg::REG_W-1:0] i_rs1,
    input  logic [rvc_pkg::REG_W-1:0] i_rs2,
    input  logic [rvc_pkg::REG_W-1:0] i_rd,
    input  logic [rvc_pkg::OP_W-1:0]  i_alu_op,
    input  logic                      i_cls_load,
    input  logic                      i_cls_store,
    input  logic                      i_cls_branch,
    input  logic                      i_cls_jump,
    input  logic                      i_cls_jreg,
    input  logic                      i_cls_lui,
    input  logic                      i_cls_reg,
    input  logic [XLEN_P-1:0]         i_imm,
    input  logic [XLEN_P-1:0]         i_offset,
    output logic                      o_valid,
    output logic                      o_is_compressed,
    output logic [1:0]                o_mem_load,
    output logic [1:0]                o_mem_store,
    output logic [2:0]                o_imm_sel,
    output logic [1:0]                o_data_sel,
    output logic                      o_sel_op_a,
    output logic                      o_sel_op_b,
    output logic                      o_wr_en,
    output logic [1:0]                o_branch_type,
    output logic [rvc_pkg::REG_W-1:0] o_rs1,
    output logic [rvc_pkg::REG_W-1:0] o_rs2,
    output logic [rvc_pkg::REG_W-1:0] o_rd,
    output logic [rvc_pkg::OP_W-1:0]  o_alu_op,
    output logic [XLEN_P-1:0]         o_imm,
    output logic [XLEN_P-1:0]         o_offset
);
    import rvc_pkg::*;

    logic [2:0] imm_sel;
    logic [1:0] data_sel;
    logic [1:0] branch_type;
    logic       wr_en;

    always_comb begin
        if (i_cls_jump || i_cls_jreg) imm_sel = IMMSEL_J;
        else if (i_cls_branch)        imm_sel = IMMSEL_B;
        else if (i_cls_lui)           imm_sel = IMMSEL_U;
        else if (i_cls_store)         imm_sel = IMMSEL_S;
        else                          imm_sel = IMMSEL_I;
    end

    assign data_sel = i_cls_jreg ? DATA_PC4 :
                      i_cls_lui  ? DATA_IMM :
                      i_cls_load ? DATA_MEM : DATA_ALU;

    assign wr_en = !(i_cls_store || i_cls_branch || i_inst == '0);  // zero word is illegal

    // funct3 bit 0 splits beqz from bnez
    assign branch_type = {i_cls_branch && !i_inst.cmp.funct3[0],
                          i_cls_branch && i_inst.cmp.funct3[0]};

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid     <= 1'b0;
            o_wr_en     <= 1'b0;
            o_mem_load  <= MEM_NONE;
            o_mem_store <= MEM_NONE;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_wr_en     <= wr_en;
                o_mem_load  <= i_cls_load ? MEM_WORD : MEM_NONE;
                o_mem_store <= i_cls_store ? MEM_WORD : MEM_NONE;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_is_compressed <= (i_inst.cmp.op != QUAD_FULL);
            o_imm_sel       <= imm_sel;
            o_data_sel      <= data_sel;
            o_sel_op_a      <= !(i_cls_lui || i_cls_jreg);  // zero or pc as operand a
            o_sel_op_b      <= !(i_cls_reg || i_cls_branch);
            o_branch_type   <= branch_type;
            o_rs1           <= i_rs1;
            o_rs2           <= i_rs2;
            o_rd            <= i_rd;
            o_alu_op        <= i_alu_op;
            o_imm           <= i_imm;
            o_offset        <= i_offset;
        end
    end

    a_valid_gap: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !i_valid |=> !o_valid);

endmodule

`default_nettype wire

//--- source/rvc_imm_gen.sv
`timescale 1ns/1ns
`default_nettype none

module rvc_imm_gen #(
    parameter int XLEN_P = rvc_pkg::XLEN
) (
    input  rvc_pkg::rvc_inst_u i_inst,
    output logic [XLEN_P-1:0]  o_imm,
    output logic [XLEN_P-1:0]  o_offset
);
    import rvc_pkg::*;

    localparam int IMM_LO_W = 18;  // lui reaches bit 17
    localparam int OFF_LO_W = 12;

    logic [INST_W-1:0]   w;
    logic [1:0]          quad;
    logic [2:0]          funct3;
    logic                unsigned_form;
    logic                scaled_form;
    logic                is_jal_j;
    logic                sgn;
    logic [IMM_LO_W-1:0] imm_lo;
    logic [OFF_LO_W-1:0] off_lo;

    assign w      = i_inst;
    assign quad   = i_inst.cmp.op;
    assign funct3 = i_inst.cmp.funct3;

    always_comb begin
        unsigned_form = 1'b0;
        scaled_form   = 1'b0;
        case (quad)
            QUAD_0: begin  // addi4spn, lw, sw
                unsigned_form = funct3 inside {3'd0, 3'd2, 3'd6};
                scaled_form   = funct3 inside {3'd0, 3'd2, 3'd6};
            end
            QUAD_1: begin
                unsigned_form = (funct3 == 3'd4) && !i_inst.cmp.hi[1];  // srli, srai
                scaled_form   = (funct3 == 3'd3) && (i_inst.full.rd_rs1 == REG_SP);
            end
            QUAD_2: begin  // lwsp, swsp
                unsigned_form = funct3 inside {3'd2, 3'd6};
                scaled_form   = funct3 inside {3'd2, 3'd6};
            end
            default: ;
        endcase
    end

    assign sgn      = w[12] && !unsigned_form;
    assign is_jal_j = (quad == QUAD_1) && (funct3 == 3'd1 || funct3 == 3'd5);

    always_comb begin
        imm_lo = {{12{sgn}}, w[12], w[6:2]};  // ci layout
        case (quad)
            QUAD_0: begin
                if (funct3 == 3'd0) begin
                    imm_lo = {8'd0, w[10:7], w[12:11], w[5], w[6], 2'b00};
                end else if (scaled_form) begin
                    imm_lo = {11'd0, w[5], w[12:10], w[6], 2'b00};  // lw, sw
                end
            end
            QUAD_1: begin
                if (funct3 == 3'd3) begin
                    if (scaled_form) begin
                        // addi16sp, multiple of 16
                        imm_lo = {{8{sgn}}, w[12], w[4:3], w[5], w[2], w[6], 4'd0};
                    end else begin
                        imm_lo = {w[12], w[6:2], 12'd0};  // lui
                    end
                end
            end
            QUAD_2: begin
                if (funct3 == 3'd2) begin
                    imm_lo = {10'd0, w[3:2], w[12], w[6:4], 2'b00};  // lwsp
                end else if (funct3 == 3'd6) begin
                    imm_lo = {10'd0, w[8:7], w[12:9], 2'b00};  // swsp
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        if (is_jal_j) begin
            off_lo = {w[12], w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
        end else begin
            off_lo = {{3{sgn}}, w[12], w[6:5], w[2], w[11:10], w[4:3], 1'b0};
        end
    end

    assign o_imm    = {{(XLEN_P-IMM_LO_W){sgn}}, imm_lo};
    assign o_offset = {{(XLEN_P-OFF_LO_W){sgn}}, off_lo};

    // memory and stack forms address whole words
    a_scaled_align: assert final (!scaled_form || o_imm[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- source/rvc_field_decode.sv
`timescale 1ns/1ns
`default_nettype none

module rvc_field_decode (
    input  rvc_pkg::rvc_inst_u        i_inst,
    output logic [rvc_pkg::REG_W-1:0] o_rs1,
    output logic [rvc_pkg::REG_W-1:0] o_rs2,
    output logic [rvc_pkg::REG_W-1:0] o_rd,
    output logic [rvc_pkg::OP_W-1:0]  o_alu_op,
    output logic                      o_cls_load,
    output logic                      o_cls_store,
    output logic                      o_cls_branch,
    output logic                      o_cls_jump,
    output logic                      o_cls_jreg,
    output logic                      o_cls_lui,
    output logic                      o_cls_reg
);
    import rvc_pkg::*;

    logic [REG_W-1:0] rd_full;
    logic [REG_W-1:0] rs2_full;
    logic [REG_W-1:0] rs1_cmp;
    logic [REG_W-1:0] rs2_cmp;
    logic             bit12;

    assign rd_full  = i_inst.full.rd_rs1;
    assign rs2_full = i_inst.full.rs2;
    assign rs1_cmp  = {2'b01, i_inst.cmp.rs1c};  // x8..x15
    assign rs2_cmp  = {2'b01, i_inst.cmp.rs2c};
    assign bit12    = i_inst.full.funct4[0];

    always_comb begin
        o_rs1        = REG_ZERO;
        o_rs2        = REG_ZERO;
        o_rd         = REG_ZERO;
        o_alu_op     = ALU_ADD;
        o_cls_load   = 1'b0;
        o_cls_store  = 1'b0;
        o_cls_branch = 1'b0;
        o_cls_jump   = 1'b0;
        o_cls_jreg   = 1'b0;
        o_cls_lui    = 1'b0;
        o_cls_reg    = 1'b0;

        case (i_inst.cmp.op)
            QUAD_0: begin
                case (i_inst.cmp.funct3)
                    3'd0: begin  // addi4spn
                        o_rd  = rs2_cmp;
                        o_rs1 = REG_SP;
                    end
                    3'd2: begin  // lw
                        o_rd       = rs2_cmp;
                        o_rs1      = rs1_cmp;
                        o_cls_load = 1'b1;
                    end
                    3'd6: begin  // sw
                        o_rs1       = rs1_cmp;
                        o_rs2       = rs2_cmp;
                        o_cls_store = 1'b1;
                    end
                    default: ;
                endcase
            end
            QUAD_1: begin
                case (i_inst.cmp.funct3)
                    3'd0: begin  // addi, nop
                        o_rd  = rd_full;
                        o_rs1 = rd_full;
                    end
                    3'd1: begin
                        o_rd       = REG_RA;  // jal links to ra
                        o_cls_jump = 1'b1;
                    end
                    3'd2: o_rd = rd_full;  // li adds to x0
                    3'd3: begin
                        o_rd = rd_full;
                        if (rd_full == REG_SP) begin
                            o_rs1 = REG_SP;  // addi16sp
                        end else begin
                            o_cls_lui = 1'b1;
                        end
                    end
                    3'd4: begin
                        // hi == 3'b111 is reserved in rv32
                        if (i_inst.cmp.hi != 3'b111) begin
                            o_rd  = rs1_cmp;
                            o_rs1 = rs1_cmp;
                        end
                        case (i_inst.cmp.hi[1:0])
                            2'd0: o_alu_op = ALU_SRL;
                            2'd1: o_alu_op = ALU_SRA;
                            2'd2: o_alu_op = ALU_AND;  // andi
                            default: begin
                                if (!i_inst.cmp.hi[2]) begin
                                    o_rs2     = rs2_cmp;
                                    o_cls_reg = 1'b1;
                                    case (i_inst.cmp.mid)
                                        2'd0:    o_alu_op = ALU_SUB;
                                        2'd1:    o_alu_op = ALU_XOR;
                                        2'd2:    o_alu_op = ALU_OR;
                                        default: o_alu_op = ALU_AND;
                                    endcase
                                end
                            end
                        endcase
                    end
                    3'd5: o_cls_jump = 1'b1;  // j, rd stays x0
                    default: begin  // beqz, bnez compare against x0
                        o_rs1        = rs1_cmp;
                        o_alu_op     = ALU_SUB;
                        o_cls_branch = 1'b1;
                    end
                endcase
            end
            QUAD_2: begin
                case (i_inst.cmp.funct3)
                    3'd0: begin  // slli
                        o_rd     = rd_full;
                        o_rs1    = rd_full;
                        o_alu_op = ALU_SLL;
                    end
                    3'd2: begin  // lwsp
                        o_rd       = rd_full;
                        o_rs1      = REG_SP;
                        o_cls_load = 1'b1;
                    end
                    3'd6: begin  // swsp
                        o_rs1       = REG_SP;
                        o_rs2       = rs2_full;
                        o_cls_store = 1'b1;
                    end
                    3'd4: begin
                        if (rs2_full != REG_ZERO) begin  // add, mv
                            o_rd      = rd_full;
                            o_rs1     = bit12 ? rd_full : REG_ZERO;
                            o_rs2     = rs2_full;
                            o_cls_reg = 1'b1;
                        end else if (!(bit12 && rd_full == REG_ZERO)) begin
                            // jr, jalr; ebreak keeps defaults
                            o_rs1      = rd_full;
                            o_rd       = bit12 ? REG_RA : REG_ZERO;
                            o_cls_jreg = 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
            default: ;  // uncompressed word
        endcase
    end

    // the control stage priorities assume a single class per word
    a_cls_onehot: assert final ($onehot0({o_cls_load, o_cls_store, o_cls_branch,
        o_cls_jump, o_cls_jreg, o_cls_lui, o_cls_reg}));

endmodule

`default_nettype wire

//--- source/rvc_pkg.sv
`default_nettype none

package rvc_pkg;

    localparam int INST_W = 16;  // compressed word
    localparam int XLEN   = 32;
    localparam int REG_W  = 5;
    localparam int OP_W   = 4;

    localparam logic [REG_W-1:0] REG_ZERO = 5'd0;
    localparam logic [REG_W-1:0] REG_RA   = 5'd1;
    localparam logic [REG_W-1:0] REG_SP   = 5'd2;

    // opcode field, inst[1:0]
    localparam logic [1:0] QUAD_0    = 2'd0;
    localparam logic [1:0] QUAD_1    = 2'd1;
    localparam logic [1:0] QUAD_2    = 2'd2;
    localparam logic [1:0] QUAD_FULL = 2'd3;  // 32-bit encoding

    localparam logic [OP_W-1:0] ALU_ADD = 4'd1;
    localparam logic [OP_W-1:0] ALU_SUB = 4'd2;
    localparam logic [OP_W-1:0] ALU_AND = 4'd3;
    localparam logic [OP_W-1:0] ALU_OR  = 4'd4;
    localparam logic [OP_W-1:0] ALU_XOR = 4'd5;
    localparam logic [OP_W-1:0] ALU_SLL = 4'd8;
    localparam logic [OP_W-1:0] ALU_SRL = 4'd9;
    localparam logic [OP_W-1:0] ALU_SRA = 4'd10;

    localparam logic [2:0] IMMSEL_I = 3'd0;
    localparam logic [2:0] IMMSEL_S = 3'd1;
    localparam logic [2:0] IMMSEL_U = 3'd2;
    localparam logic [2:0] IMMSEL_B = 3'd3;
    localparam logic [2:0] IMMSEL_J = 3'd4;

    // write-back source
    localparam logic [1:0] DATA_PC4 = 2'd0;
    localparam logic [1:0] DATA_ALU = 2'd1;
    localparam logic [1:0] DATA_IMM = 2'd2;
    localparam logic [1:0] DATA_MEM = 2'd3;

    localparam logic [1:0] MEM_NONE = 2'd0;
    localparam logic [1:0] MEM_WORD = 2'd2;

    // full view for CR/CI forms, compact view for x8..x15 forms
    typedef union packed {
        struct packed {
            logic [3:0]       funct4;
            logic [REG_W-1:0] rd_rs1;
            logic [REG_W-1:0] rs2;
            logic [1:0]       op;
        } full;
        struct packed {
            logic [2:0] funct3;
            logic [2:0] hi;    // funct4 bit and funct2 in CA/CB
            logic [2:0] rs1c;
            logic [1:0] mid;   // CA sub-function
            logic [2:0] rs2c;
            logic [1:0] op;
        } cmp;
    } rvc_inst_u;

endpackage

`default_nettype wire
